//--- all.f
+incdir+bench
common/divSqrtPkg.sv
src/operandPrep.sv
recurrence/recurrenceCtrl.sv
recurrence/iterationArray.sv
recurrence/recurrenceCore.sv
src/resultCorrect.sv
src/divSqrtTop.sv
bench/divSqrtTb.sv

//--- bench/divSqrtModel.svh
// divide/sqrt reference model for the fixed point quotient, integer root and result exponent
`ifndef DIV_SQRT_MODEL_SVH
`define DIV_SQRT_MODEL_SVH

// floor of a/b with 23 fraction bits
function automatic mant_t modelQuotient(input mant_t a, input mant_t b);
  longint unsigned num;
  num = a;
  num = num << 23;
  return mant_t'(num / b);
endfunction

// even biased exponent means odd true exponent, so the radicand doubles
function automatic logic [MantWidth:0] alignRadicand(input mant_t a, input exp_t ea);
  logic [MantWidth:0] rad;
  if (ea[0])
    rad = {1'b0, a};
  else
    rad = {a, 1'b0};
  return rad;
endfunction

// bitwise integer square root of the aligned radicand scaled by 2^23
function automatic mant_t modelRoot(input mant_t a, input exp_t ea);
  longint unsigned rad;
  longint unsigned root;
  longint unsigned trial;
  rad  = alignRadicand(a, ea);
  rad  = rad << 23;
  root = 0;
  for (int i = MantWidth - 1; i >= 0; i--)
  begin
    trial = root | (64'd1 << i);
    if (trial * trial <= rad)
      root = trial;  // keep this bit
  end
  return mant_t'(root);
endfunction

function automatic expRes_t modelDivExp(input exp_t ea, input exp_t eb);
  int e;
  e = int'(ea) - int'(eb) + int'(ExpBias);
  return expRes_t'(e);
endfunction

function automatic expRes_t modelSqrtExp(input exp_t ea);
  int e;
  e = int'(ea) / 2 + int'(ea[0]) + int'(ExpHalfBias);  // odd exponent rounds the half up
  return expRes_t'(e);
endfunction

`endif

//--- bench/divSqrtTb.sv
// divSqrtTb drives random divisions and square roots and checks them against a reference model
`timescale 1ns/1ps

module divSqrtTb import divSqrtPkg::*;
();

  localparam int unsigned DigitsPerCycle = 4;
  localparam int unsigned Latency        = MantWidth / DigitsPerCycle + 2;
  localparam int unsigned NumDiv         = 200;
  localparam int unsigned NumSqrt        = 200;
  localparam int unsigned NumEdge        = 7;
  localparam int unsigned NumBusy        = 2;
  localparam int unsigned NumChain       = 8;
  localparam int unsigned NumOps         = NumDiv + NumSqrt + NumEdge + NumBusy + NumChain;
  localparam int unsigned TimeoutCycles  = NumOps * (Latency + 4) + 100;

  logic    Clk_CI;
  logic    Rst_RBI;
  logic    DivStart;
  logic    SqrtStart;
  mant_t   MantA;
  mant_t   MantB;
  exp_t    ExpA;
  exp_t    ExpB;
  logic    Ready;
  logic    Done;
  mant_t   MantResult;
  expRes_t ExpResult;

  mant_t   pendMant;  // expected result of the running operation
  expRes_t pendExp;
  mant_t   lastMant;  // last completed result
  int      errCount;
  int      cycleCnt = 0;

  `include "divSqrtModel.svh"

  divSqrtTop #(
    .DigitsPerCycle (DigitsPerCycle)
  ) i_dut (
    .Clk_CI     (Clk_CI),
    .Rst_RBI    (Rst_RBI),
    .DivStart   (DivStart),
    .SqrtStart  (SqrtStart),
    .MantA      (MantA),
    .MantB      (MantB),
    .ExpA       (ExpA),
    .ExpB       (ExpB),
    .Ready      (Ready),
    .Done       (Done),
    .MantResult (MantResult),
    .ExpResult  (ExpResult)
  );

  always #5 Clk_CI = ~Clk_CI;

  always @(posedge Clk_CI)
  begin
    cycleCnt <= cycleCnt + 1;
    if (cycleCnt >= TimeoutCycles)
    begin
      $display("CHECKS FAILED");
      $fatal(1, "timeout, the test sequence did not finish within %0d cycles", TimeoutCycles);
    end
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual)
    begin
      errCount++;
      $display("ERR %s: expected %0h, actual %0h", name, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1, "value mismatch in %s", name);
    end
  endtask

  task automatic nextDrive();
    @(posedge Clk_CI);
    #1;
  endtask

  function automatic mant_t randMant();
    return {1'b1, 23'($urandom)};  // hidden bit set
  endfunction

  function automatic exp_t randExp();
    return exp_t'(1 + $urandom % 254);
  endfunction

  task automatic issueOp(input string name, input opKind_e kind, input mant_t a,
                         input mant_t b, input exp_t ea, input exp_t eb);
    checkValue({name, " ready at start"}, 1, Ready);
    DivStart  = (kind == OpDiv);
    SqrtStart = (kind == OpSqrt);
    MantA     = a;
    MantB     = b;
    ExpA      = ea;
    ExpB      = eb;
    if (kind == OpDiv)
    begin
      pendMant = modelQuotient(a, b);
      pendExp  = modelDivExp(ea, eb);
    end
    else
    begin
      pendMant = modelRoot(a, ea);
      pendExp  = modelSqrtExp(ea);
    end
    nextDrive();
    DivStart  = 1'b0;
    SqrtStart = 1'b0;
    MantA     = randMant();  // operands already captured
    MantB     = randMant();
    ExpA      = randExp();
    ExpB      = randExp();
  endtask

  task automatic awaitResult(input string name, input bit injectBusy);
    int cycles;
    cycles = 0;
    while (!Done && cycles <= Latency)
    begin
      checkValue({name, " ready busy"}, 0, Ready);
      checkValue({name, " exponent early"}, pendExp, ExpResult);
      checkValue({name, " mantissa before done"}, lastMant, MantResult);
      if (injectBusy && cycles == 2)
      begin
        SqrtStart = 1'b1;  // must be ignored while busy
        MantA     = randMant();
        MantB     = randMant();
        ExpA      = randExp();
        ExpB      = randExp();
      end
      else if (injectBusy && cycles == 3)
        SqrtStart = 1'b0;
      nextDrive();
      cycles++;
    end
    // visible after edge L-1, sampled at edge L
    checkValue({name, " latency"}, Latency - 1, cycles);
    checkValue({name, " mantissa"}, pendMant, MantResult);
    checkValue({name, " exponent"}, pendExp, ExpResult);
    checkValue({name, " ready at done"}, 1, Ready);
    lastMant = pendMant;
  endtask

  task automatic checkIdle(input string name);
    nextDrive();
    checkValue({name, " done pulse"}, 0, Done);
    checkValue({name, " ready idle"}, 1, Ready);
    checkValue({name, " mantissa hold"}, lastMant, MantResult);
    checkValue({name, " exponent hold"}, pendExp, ExpResult);
  endtask

  task automatic runOp(input string name, input opKind_e kind, input mant_t a, input mant_t b,
                       input exp_t ea, input exp_t eb, input bit injectBusy, input bit chain);
    issueOp(name, kind, a, b, ea, eb);
    awaitResult(name, injectBusy);
    if (!chain)
      checkIdle(name);
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial
  begin
    mant_t a;
    exp_t  ea;
    Clk_CI    = 1'b0;
    Rst_RBI   = 1'b0;
    DivStart  = 1'b0;
    SqrtStart = 1'b0;
    MantA     = '0;
    MantB     = '0;
    ExpA      = '0;
    ExpB      = '0;
    errCount  = 0;
    lastMant  = '0;
    pendMant  = '0;
    pendExp   = '0;
    void'($urandom(32'h777b4476));

    repeat (3) @(posedge Clk_CI);
    #1;
    Rst_RBI = 1'b1;
    checkValue("reset ready", 1, Ready);
    checkValue("reset done", 0, Done);
    checkValue("reset mantissa", 0, MantResult);
    nextDrive();

    for (int i = 0; i < NumDiv; i++)
      runOp($sformatf("div %0d", i), OpDiv, randMant(), randMant(), randExp(), randExp(),
            1'b0, 1'b0);

    // alternate exponent parity
    for (int i = 0; i < NumSqrt; i++)
    begin
      ea = (i % 2) ? exp_t'(1 + 2 * ($urandom % 127)) : exp_t'(2 + 2 * ($urandom % 127));
      runOp($sformatf("sqrt %0d", i), OpSqrt, randMant(), randMant(), ea, randExp(),
            1'b0, 1'b0);
    end

    a = randMant();
    runOp("div equal", OpDiv, a, a, 8'd100, 8'd100, 1'b0, 1'b0);
    runOp("sqrt equal", OpSqrt, a, a, 8'd200, 8'd1, 1'b0, 1'b0);
    runOp("sqrt min odd", OpSqrt, 24'h800000, 24'h800000, 8'd127, 8'd1, 1'b0, 1'b0);
    runOp("sqrt min even", OpSqrt, 24'h800000, 24'h800000, 8'd128, 8'd1, 1'b0, 1'b0);
    runOp("sqrt max even", OpSqrt, 24'hffffff, 24'h800000, 8'd254, 8'd1, 1'b0, 1'b0);
    runOp("div min", OpDiv, 24'h800000, 24'hffffff, 8'd1, 8'd254, 1'b0, 1'b0);
    runOp("div max", OpDiv, 24'hffffff, 24'h800000, 8'd254, 8'd1, 1'b0, 1'b0);

    // stray strobe in the busy window
    runOp("div busy", OpDiv, randMant(), randMant(), randExp(), randExp(), 1'b1, 1'b0);
    runOp("sqrt busy", OpSqrt, randMant(), randMant(), randExp(), randExp(), 1'b1, 1'b0);

    // next start in the done cycle
    for (int i = 0; i < NumChain; i++)
      runOp($sformatf("chain %0d", i), (i % 2) ? OpSqrt : OpDiv, randMant(), randMant(),
            randExp(), randExp(), 1'b0, (i < NumChain - 1));

    if (errCount == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

//--- src/divSqrtTop.sv
// divSqrtTop joins operand capture, digit recurrence and result correction of the divide/sqrt unit
`timescale 1ns/1ps

module divSqrtTop import divSqrtPkg::*;
#(
  parameter int unsigned DigitsPerCycle = 4  // must divide the mantissa width
)
(
  input  logic    Clk_CI,
  input  logic    Rst_RBI,
  input  logic    DivStart,
  input  logic    SqrtStart,
  input  mant_t   MantA,
  input  mant_t   MantB,
  input  exp_t    ExpA,
  input  exp_t    ExpB,
  output logic    Ready,
  output logic    Done,
  output mant_t   MantResult,
  output expRes_t ExpResult
);

  opKind_e            opKind;
  mant_t              divisorMant;
  logic [MantWidth:0] radicandMant;  // also carries the dividend
  logic               load;
  logic               step;
  logic               correctEn;
  mant_t              quotient;
  rem_t               remainder;

  //////////////////////////////////////////////////
  // input side
  //////////////////////////////////////////////////

  operandPrep i_operandPrep (
    .Clk_CI       (Clk_CI),
    .Rst_RBI      (Rst_RBI),
    .DivStart     (DivStart),
    .SqrtStart    (SqrtStart),
    .Ready        (Ready),
    .MantA        (MantA),
    .MantB        (MantB),
    .ExpA         (ExpA),
    .ExpB         (ExpB),
    .OpKind       (opKind),
    .DivisorMant  (divisorMant),
    .RadicandMant (radicandMant),
    .ExpResult    (ExpResult)
  );

  //////////////////////////////////////////////////
  // recurrence
  //////////////////////////////////////////////////

  recurrenceCtrl #(
    .DigitsPerCycle (DigitsPerCycle)
  ) i_recurrenceCtrl (
    .Clk_CI    (Clk_CI),
    .Rst_RBI   (Rst_RBI),
    .DivStart  (DivStart),
    .SqrtStart (SqrtStart),
    .Ready     (Ready),
    .Load      (load),
    .Step      (step),
    .CorrectEn (correctEn)
  );

  recurrenceCore #(
    .DigitsPerCycle (DigitsPerCycle)
  ) i_recurrenceCore (
    .Clk_CI       (Clk_CI),
    .Rst_RBI      (Rst_RBI),
    .OpKind       (opKind),
    .Load         (load),
    .Step         (step),
    .DivisorMant  (divisorMant),
    .RadicandMant (radicandMant),
    .Quotient     (quotient),
    .Remainder    (remainder)
  );

  // output side
  resultCorrect i_resultCorrect (
    .Clk_CI     (Clk_CI),
    .Rst_RBI    (Rst_RBI),
    .CorrectEn  (correctEn),
    .Quotient   (quotient),
    .Remainder  (remainder),
    .MantResult (MantResult),
    .Done       (Done)
  );

endmodule

//--- src/resultCorrect.sv
// resultCorrect applies the final remainder sign correction and registers the mantissa result
`timescale 1ns/1ps

module resultCorrect import divSqrtPkg::*;
(
  input  logic  Clk_CI,
  input  logic  Rst_RBI,
  input  logic  CorrectEn,
  input  mant_t Quotient,
  input  rem_t  Remainder,
  output mant_t MantResult,
  output logic  Done
);

  logic  remNeg;
  mant_t corrected;

  //////////////////////////////////////////////////
  // sign correction
  //////////////////////////////////////////////////

  assign remNeg    = Remainder[RemWidth-1];
  assign corrected = remNeg ? Quotient - mant_t'(1) : Quotient;  // one step too far

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      MantResult <= '0;
      Done       <= 1'b0;
    end
    else
    begin
      Done <= CorrectEn;
      if (CorrectEn)
        MantResult <= corrected;  // held until the next operation corrects
    end
  end

  // correct strobe from the controller is a single pulse
  aDonePulse: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    Done |=> !Done);

endmodule

//--- recurrence/recurrenceCore.sv
// recurrenceCore holds the partial remainder, partial quotient and radicand for the iteration array
`timescale 1ns/1ps

module recurrenceCore import divSqrtPkg::*;
#(
  parameter int unsigned DigitsPerCycle = 4
)
(
  input  logic               Clk_CI,
  input  logic               Rst_RBI,
  input  opKind_e            OpKind,
  input  logic               Load,
  input  logic               Step,
  input  mant_t              DivisorMant,
  input  logic [MantWidth:0] RadicandMant,
  output mant_t              Quotient,
  output rem_t               Remainder
);

  // radicand plus the zero that pads its last pair
  localparam int unsigned RadWidth = MantWidth + 2;

  rem_t                        remQ;
  rem_t                        remInit;
  rem_t                        remCur;
  rem_t                        remNext;
  mant_t                       quotQ;
  mant_t                       quotCur;
  mant_t                       quotNext;
  logic [RadWidth-1:0]         radQ;
  logic [RadWidth-1:0]         radCur;
  logic [2*DigitsPerCycle-1:0] radBits;

  // division starts from the dividend and square root from zero
  assign remInit = (OpKind == OpDiv) ? {{(RemWidth-MantWidth-1){1'b0}}, RadicandMant} : '0;

  // load cycle already iterates on the fresh operands
  assign remCur  = Load ? remInit : remQ;
  assign quotCur = Load ? '0 : quotQ;
  assign radCur  = Load ? {RadicandMant, 1'b0} : radQ;
  assign radBits = radCur[RadWidth-1 -: 2*DigitsPerCycle];

  iterationArray #(
    .DigitsPerCycle (DigitsPerCycle)
  ) i_iterationArray (
    .OpKind        (OpKind),
    .Remainder     (remCur),
    .Quotient      (quotCur),
    .DivisorMant   (DivisorMant),
    .RadicandBits  (radBits),
    .NextRemainder (remNext),
    .NextQuotient  (quotNext)
  );

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      remQ  <= '0;
      quotQ <= '0;
      radQ  <= '0;
    end
    else if (Step)
    begin
      remQ  <= remNext;
      quotQ <= quotNext;
      radQ  <= radCur << (2*DigitsPerCycle);  // zeros follow the last radicand pair
    end
  end

  // signed-digit quotient form
  // the last digit stands as +1 until the final remainder sign decides it
  assign Quotient  = {quotQ[MantWidth-1:1], 1'b1};
  assign Remainder = remQ;

endmodule

//--- recurrence/iterationArray.sv
// iterationArray is the non-restoring add/subtract chain retiring several quotient or root bits
`timescale 1ns/1ps

module iterationArray import divSqrtPkg::*;
#(
  parameter int unsigned DigitsPerCycle = 4
)
(
  input  opKind_e                     OpKind,
  input  rem_t                        Remainder,
  input  mant_t                       Quotient,
  input  mant_t                       DivisorMant,
  input  logic [2*DigitsPerCycle-1:0] RadicandBits,  // next pairs, msb pair first
  output rem_t                        NextRemainder,
  output mant_t                       NextQuotient
);

  rem_t  remChain  [DigitsPerCycle+1];
  mant_t quotChain [DigitsPerCycle+1];
  rem_t  divOperand;

  // division remainder carries one fraction bit
  // so every cell doubles and the first one still sees the plain dividend
  assign divOperand   = {{(RemWidth-MantWidth-1){1'b0}}, DivisorMant, 1'b0};

  assign remChain[0]  = Remainder;
  assign quotChain[0] = Quotient;

  //////////////////////////////////////////////////
  // cell chain
  //////////////////////////////////////////////////

  for (genvar i = 0; i < DigitsPerCycle; i++)
  begin : genCell
    logic [1:0] radPair;
    logic       prevNeg;
    rem_t       shifted;
    rem_t       operand;
    rem_t       sum;

    assign radPair = RadicandBits[2*(DigitsPerCycle-i)-1 -: 2];
    assign prevNeg = remChain[i][RemWidth-1];

    always_comb
    begin
      if (OpKind == OpSqrt)
      begin
        shifted = {remChain[i][RemWidth-3:0], radPair};  // 4r plus next pair
        operand = {1'b0, quotChain[i], prevNeg, 1'b1};   // 4q+1 or 4q+3
      end
      else
      begin
        shifted = {remChain[i][RemWidth-2:0], 1'b0};
        operand = divOperand;
      end
      // negative remainder adds back
      sum = prevNeg ? shifted + operand : shifted - operand;
    end

    assign remChain[i+1]  = sum;
    assign quotChain[i+1] = {quotChain[i][MantWidth-2:0], ~sum[RemWidth-1]};  // new digit
  end

  assign NextRemainder = remChain[DigitsPerCycle];
  assign NextQuotient  = quotChain[DigitsPerCycle];

endmodule

//--- recurrence/recurrenceCtrl.sv
// recurrenceCtrl sequences one divide/sqrt operation and drives ready, load, step and correct
`timescale 1ns/1ps

module recurrenceCtrl import divSqrtPkg::*;
#(
  parameter int unsigned DigitsPerCycle = 4
)
(
  input  logic Clk_CI,
  input  logic Rst_RBI,
  input  logic DivStart,
  input  logic SqrtStart,
  output logic Ready,
  output logic Load,
  output logic Step,
  output logic CorrectEn
);

  localparam int unsigned IterCycles = MantWidth / DigitsPerCycle;
  localparam int unsigned CntWidth   = $clog2(IterCycles + 1);

  ctrlState_e          stateQ;
  ctrlState_e          stateD;
  logic [CntWidth-1:0] cntQ;   // iteration cycles done
  logic                start;
  logic                lastIter;

  assign start    = DivStart | SqrtStart;
  assign lastIter = (cntQ == CntWidth'(IterCycles - 1));

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_comb
  begin
    stateD = stateQ;
    case (stateQ)
      Idle:
      begin
        if (start)
          stateD = Iterate;
      end
      Iterate:
      begin
        if (lastIter)
          stateD = Correct;
      end
      Correct:
        stateD = Finish;
      Finish:
      begin
        // done cycle accepts the next operation directly
        stateD = start ? Iterate : Idle;
      end
      default:
        stateD = Idle;
    endcase
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      stateQ <= Idle;
      cntQ   <= '0;
    end
    else
    begin
      stateQ <= stateD;
      if (stateQ == Iterate && !lastIter)
        cntQ <= cntQ + 1'b1;
      else
        cntQ <= '0;
    end
  end

  assign Ready     = (stateQ == Idle) || (stateQ == Finish);
  assign Step      = (stateQ == Iterate);
  assign Load      = Step && (cntQ == '0);  // first iteration cycle
  assign CorrectEn = (stateQ == Correct);

  // start strobes are exclusive
  aStartExcl: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    !(DivStart && SqrtStart));

  // step window never runs past the digit count
  aStepLen: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    Step [*IterCycles] |=> !Step);

endmodule

//--- src/operandPrep.sv
// operandPrep captures divide/sqrt operands on an accepted start and forms the result exponent
`timescale 1ns/1ps

module operandPrep import divSqrtPkg::*;
(
  input  logic               Clk_CI,
  input  logic               Rst_RBI,
  input  logic               DivStart,
  input  logic               SqrtStart,
  input  logic               Ready,
  input  mant_t              MantA,
  input  mant_t              MantB,
  input  exp_t               ExpA,
  input  exp_t               ExpB,
  output opKind_e            OpKind,
  output mant_t              DivisorMant,
  output logic [MantWidth:0] RadicandMant,
  output expRes_t            ExpResult
);

  logic                   accept;
  opKind_e                kindIn;
  logic [MantWidth:0]     radIn;
  logic [ExpResWidth-1:0] expAExt;
  logic [ExpResWidth-1:0] expBExt;
  expRes_t                divExp;
  expRes_t                sqrtExp;

  assign accept = Ready & (DivStart | SqrtStart);  // strobes while busy are dropped
  assign kindIn = SqrtStart ? OpSqrt : OpDiv;

  //////////////////////////////////////////////////
  // radicand alignment
  //////////////////////////////////////////////////

  // an even biased exponent means an odd true exponent
  // so the mantissa is doubled and the halved exponent stays whole
  always_comb
  begin
    if (kindIn == OpSqrt && !ExpA[0])
      radIn = {MantA, 1'b0};
    else
      radIn = {1'b0, MantA};  // dividend for a division
  end

  //////////////////////////////////////////////////
  // exponent
  //////////////////////////////////////////////////

  assign expAExt = {{(ExpResWidth-ExpWidth){1'b0}}, ExpA};
  assign expBExt = {{(ExpResWidth-ExpWidth){1'b0}}, ExpB};

  assign divExp  = expAExt - expBExt + ExpResWidth'(ExpBias);
  assign sqrtExp = (expAExt >> 1) + ExpResWidth'(ExpA[0]) + ExpResWidth'(ExpHalfBias);

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      OpKind       <= OpDiv;
      DivisorMant  <= '0;
      RadicandMant <= '0;
      ExpResult    <= '0;
    end
    else if (accept)
    begin
      OpKind       <= kindIn;
      DivisorMant  <= MantB;
      RadicandMant <= radIn;
      ExpResult    <= (kindIn == OpSqrt) ? sqrtExp : divExp;  // valid one cycle after acceptance
    end
  end

endmodule

//--- common/divSqrtPkg.sv
// divide/sqrt shared definitions with operand widths, bias constants, data types and enums
package divSqrtPkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  parameter int unsigned MantWidth   = 24;  // hidden bit included
  parameter int unsigned ExpWidth    = 8;   // biased input exponent
  parameter int unsigned ExpResWidth = 10;  // signed prenormalized exponent

  // sign plus two guard bits above the mantissa
  parameter int unsigned RemWidth    = MantWidth + 3;

  //////////////////////////////////////////////////
  // exponent constants
  //////////////////////////////////////////////////

  parameter int unsigned ExpBias     = 127;
  parameter int unsigned ExpHalfBias = 63;  // bias share kept by a square root

  //////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////

  typedef logic [MantWidth-1:0]          mant_t;
  typedef logic [ExpWidth-1:0]           exp_t;
  typedef logic signed [ExpResWidth-1:0] expRes_t;
  typedef logic [RemWidth-1:0]           rem_t;  // two's complement with the sign in the msb

  typedef enum logic
  {
    OpDiv  = 1'b0,
    OpSqrt = 1'b1
  } opKind_e;

  // controller sequence of one operation
  typedef enum logic [1:0]
  {
    Idle    = 2'b00,
    Iterate = 2'b01,
    Correct = 2'b10,
    Finish  = 2'b11
  } ctrlState_e;

endpackage
